// ==== src/rv_decode_pkg.sv ====
package rv_decode_pkg;

// ----------------------------------------
// Widths

localparam int W_ADDR    = 32;
localparam int W_DATA    = 32;
localparam int W_REGADDR = 5;
localparam int W_ALUOP   = 4;
localparam int W_ALUSRC  = 1;
localparam int W_MEMOP   = 4;
localparam int W_MULOP   = 3;
localparam int W_BCOND   = 2;
localparam int W_EXCEPT  = 3;

// ----------------------------------------
// Core constants

localparam logic [W_ADDR-1:0]    RESET_VECTOR = 32'h0000_0040;
localparam logic [W_REGADDR-1:0] X0           = '0;
localparam logic [W_ADDR-1:0]    PC_STEP      = 32'd4;

// Major opcodes, bits 6:0 of the instruction
localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
localparam logic [6:0] OPC_STORE  = 7'b010_0011;
localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
localparam logic [6:0] OPC_JAL    = 7'b110_1111;
localparam logic [6:0] OPC_JALR   = 7'b110_0111;
localparam logic [6:0] OPC_LUI    = 7'b011_0111;
localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
localparam logic [6:0] OPC_OP     = 7'b011_0011;
localparam logic [6:0] OPC_FENCE  = 7'b000_1111;
localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

localparam logic [6:0] FUNCT7_MULDIV = 7'b000_0001;
localparam logic [6:0] FUNCT7_ALT    = 7'b010_0000;

// ----------------------------------------
// Execute control encodings

localparam logic [W_ALUOP-1:0] ALUOP_ADD    = 4'h0;
localparam logic [W_ALUOP-1:0] ALUOP_SUB    = 4'h1;
localparam logic [W_ALUOP-1:0] ALUOP_LT     = 4'h2;
localparam logic [W_ALUOP-1:0] ALUOP_LTU    = 4'h4;
localparam logic [W_ALUOP-1:0] ALUOP_XOR    = 4'h6;
localparam logic [W_ALUOP-1:0] ALUOP_OR     = 4'h7;
localparam logic [W_ALUOP-1:0] ALUOP_AND    = 4'h8;
localparam logic [W_ALUOP-1:0] ALUOP_SRL    = 4'h9;
localparam logic [W_ALUOP-1:0] ALUOP_SRA    = 4'ha;
localparam logic [W_ALUOP-1:0] ALUOP_SLL    = 4'hb;
localparam logic [W_ALUOP-1:0] ALUOP_RS2    = 4'h3;
localparam logic [W_ALUOP-1:0] ALUOP_MULDIV = 4'hc;

localparam logic [W_ALUSRC-1:0] ALUSRCA_RS1 = 1'b0;
localparam logic [W_ALUSRC-1:0] ALUSRCA_PC  = 1'b1;
localparam logic [W_ALUSRC-1:0] ALUSRCB_RS2 = 1'b0;
localparam logic [W_ALUSRC-1:0] ALUSRCB_IMM = 1'b1;

localparam logic [W_MEMOP-1:0] MEMOP_LW   = 4'h0;
localparam logic [W_MEMOP-1:0] MEMOP_LH   = 4'h1;
localparam logic [W_MEMOP-1:0] MEMOP_LB   = 4'h2;
localparam logic [W_MEMOP-1:0] MEMOP_LHU  = 4'h3;
localparam logic [W_MEMOP-1:0] MEMOP_LBU  = 4'h4;
localparam logic [W_MEMOP-1:0] MEMOP_SW   = 4'h5;
localparam logic [W_MEMOP-1:0] MEMOP_SH   = 4'h6;
localparam logic [W_MEMOP-1:0] MEMOP_SB   = 4'h7;
localparam logic [W_MEMOP-1:0] MEMOP_NONE = 4'hf;

// Numbered as funct3 of the M instructions
localparam logic [W_MULOP-1:0] M_OP_MUL    = 3'd0;
localparam logic [W_MULOP-1:0] M_OP_MULH   = 3'd1;
localparam logic [W_MULOP-1:0] M_OP_MULHSU = 3'd2;
localparam logic [W_MULOP-1:0] M_OP_MULHU  = 3'd3;
localparam logic [W_MULOP-1:0] M_OP_DIV    = 3'd4;
localparam logic [W_MULOP-1:0] M_OP_DIVU   = 3'd5;
localparam logic [W_MULOP-1:0] M_OP_REM    = 3'd6;
localparam logic [W_MULOP-1:0] M_OP_REMU   = 3'd7;

localparam logic [W_BCOND-1:0] BCOND_NEVER  = 2'b00;
localparam logic [W_BCOND-1:0] BCOND_ALWAYS = 2'b01;
localparam logic [W_BCOND-1:0] BCOND_ZERO   = 2'b10;
localparam logic [W_BCOND-1:0] BCOND_NZERO  = 2'b11;

localparam logic [W_EXCEPT-1:0] EXCEPT_NONE          = 3'd0;
localparam logic [W_EXCEPT-1:0] EXCEPT_INSTR_FAULT   = 3'd1;
localparam logic [W_EXCEPT-1:0] EXCEPT_INSTR_ILLEGAL = 3'd2;
localparam logic [W_EXCEPT-1:0] EXCEPT_ECALL_M       = 3'd3;
localparam logic [W_EXCEPT-1:0] EXCEPT_EBREAK        = 3'd4;

// ----------------------------------------
// Instruction word, register and immediate views

typedef union packed {
	struct packed {
		logic [6:0]           funct7;
		logic [W_REGADDR-1:0] rs2;
		logic [W_REGADDR-1:0] rs1;
		logic [2:0]           funct3;
		logic [W_REGADDR-1:0] rd;
		logic [6:0]           opcode;
	} r;
	struct packed {
		logic [11:0]          imm12;
		logic [W_REGADDR-1:0] rs1;
		logic [2:0]           funct3;
		logic [W_REGADDR-1:0] rd;
		logic [6:0]           opcode;
	} i;
} instr_t;

endpackage

// ==== src/rv_pc_ctrl.sv ====
`timescale 1ns/10ps

module rv_pc_ctrl
	import rv_decode_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,

	input  logic [1:0]        fd_cir_vld_i,
	input  logic [1:0]        fd_cir_err_i,
	input  logic              x_stall_i,
	input  logic              f_jump_now_i,
	input  logic [W_ADDR-1:0] f_jump_target_i,

	output logic [W_ADDR-1:0] d_pc_o,
	output logic [1:0]        df_cir_use_o,
	output logic              d_starved_o,
	output logic              d_bus_fault_o
);

logic              accept;
logic [W_ADDR-1:0] pc;

// Every instruction is 32 bits, so both halfwords must be present
assign d_starved_o = fd_cir_vld_i < 2'd2;
assign accept      = !d_starved_o && !x_stall_i;

// Fetch drops the consumed halfwords from its buffer
assign df_cir_use_o = accept ? 2'd2 : 2'd0;

// An error only counts on a halfword that fetch marked valid
assign d_bus_fault_o = (fd_cir_vld_i > 2'd0 && fd_cir_err_i[0]) ||
	(fd_cir_vld_i > 2'd1 && fd_cir_err_i[1]);

// ----------------------------------------
// Decode PC

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		pc <= RESET_VECTOR;
	end else if (f_jump_now_i) begin
		// Jump wins over stall and over a sequential step
		pc <= f_jump_target_i;
	end else if (accept) begin
		pc <= pc + PC_STEP;
	end
end

assign d_pc_o = pc;

endmodule

// ==== src/rv_imm_gen.sv ====
`timescale 1ns/10ps

module rv_imm_gen
	import rv_decode_pkg::*;
(
	input  instr_t            instr_i,

	output logic [W_DATA-1:0] imm_i_o,
	output logic [W_DATA-1:0] imm_u_o,
	output logic [W_DATA-1:0] imm_j_o,
	output logic [W_DATA-1:0] addr_offs_o
);

logic [W_DATA-1:0] imm_s;
logic [W_DATA-1:0] imm_b;
logic              sign;

assign sign = instr_i.i.imm12[11];

// ----------------------------------------
// Immediate formats

assign imm_i_o = {{20{sign}}, instr_i.i.imm12};

// S and B keep their low bits in the rd field
assign imm_s = {{20{sign}}, instr_i.i.imm12[11:5], instr_i.i.rd};
assign imm_b = {{20{sign}}, instr_i.i.rd[0], instr_i.i.imm12[10:5],
	instr_i.i.rd[4:1], 1'b0};

assign imm_u_o = {instr_i.i.imm12, instr_i.i.rs1, instr_i.i.funct3, 12'h000};

// J format scatters bits 19:12 over rs1 and funct3
assign imm_j_o = {{12{sign}}, instr_i.i.rs1, instr_i.i.funct3,
	instr_i.i.imm12[0], instr_i.i.imm12[10:1], 1'b0};

// ----------------------------------------
// Address offset for the execute-stage adder

always_comb begin
	case (instr_i.i.opcode)
	OPC_JAL:    addr_offs_o = imm_j_o;
	OPC_BRANCH: addr_offs_o = imm_b;
	OPC_STORE:  addr_offs_o = imm_s;
	OPC_JALR:   addr_offs_o = imm_i_o;
	OPC_LOAD:   addr_offs_o = imm_i_o;
	default:    addr_offs_o = '0;
	endcase
end

endmodule

// ==== src/rv_ctrl_decode.sv ====
`timescale 1ns/10ps

module rv_ctrl_decode
	import rv_decode_pkg::*;
(
	input  instr_t               instr_i,
	input  logic [W_DATA-1:0]    imm_i_i,
	input  logic [W_DATA-1:0]    imm_u_i,
	input  logic [W_DATA-1:0]    imm_j_i,
	input  logic                 starved_i,
	input  logic                 bus_fault_i,

	output logic [W_REGADDR-1:0] d_rs1_o,
	output logic [W_REGADDR-1:0] d_rs2_o,
	output logic [W_REGADDR-1:0] d_rd_o,
	output logic [W_DATA-1:0]    d_imm_o,
	output logic [W_ALUSRC-1:0]  d_alusrc_a_o,
	output logic [W_ALUSRC-1:0]  d_alusrc_b_o,
	output logic [W_ALUOP-1:0]   d_aluop_o,
	output logic [W_MEMOP-1:0]   d_memop_o,
	output logic [W_MULOP-1:0]   d_mulop_o,
	output logic [W_BCOND-1:0]   d_branchcond_o,
	output logic                 d_addr_is_regoffs_o,
	output logic [W_EXCEPT-1:0]  d_except_o
);

logic       invalid;
logic [2:0] funct3;
logic [6:0] funct7;
logic       sys_base;

// Shared ALU mapping for the register and immediate forms
function automatic logic [W_ALUOP-1:0] alu_from_funct3(input logic [2:0] f3, input logic alt);
	case (f3)
	3'b000:  alu_from_funct3 = alt ? ALUOP_SUB : ALUOP_ADD;
	3'b001:  alu_from_funct3 = ALUOP_SLL;
	3'b010:  alu_from_funct3 = ALUOP_LT;
	3'b011:  alu_from_funct3 = ALUOP_LTU;
	3'b100:  alu_from_funct3 = ALUOP_XOR;
	3'b101:  alu_from_funct3 = alt ? ALUOP_SRA : ALUOP_SRL;
	3'b110:  alu_from_funct3 = ALUOP_OR;
	default: alu_from_funct3 = ALUOP_AND;
	endcase
endfunction

assign funct3 = instr_i.r.funct3;
assign funct7 = instr_i.r.funct7;

// ECALL and EBREAK differ only in bit 20
assign sys_base = funct7 == 7'd0 && instr_i.r.rs2[4:1] == 4'd0 &&
	instr_i.r.rs1 == X0 && funct3 == 3'd0 && instr_i.r.rd == X0;

always_comb begin
	d_rs1_o             = instr_i.r.rs1;
	d_rs2_o             = instr_i.r.rs2;
	d_rd_o              = instr_i.r.rd;
	d_imm_o             = imm_i_i;
	d_alusrc_a_o        = ALUSRCA_RS1;
	d_alusrc_b_o        = ALUSRCB_RS2;
	d_aluop_o           = ALUOP_ADD;
	d_memop_o           = MEMOP_NONE;
	d_mulop_o           = M_OP_MUL;
	d_branchcond_o      = BCOND_NEVER;
	d_addr_is_regoffs_o = 1'b0;
	d_except_o          = EXCEPT_NONE;
	invalid             = 1'b0;

	case (instr_i.r.opcode)
	OPC_BRANCH: begin
		d_rd_o         = X0;
		d_aluop_o      = funct3[2] ? (funct3[1] ? ALUOP_LTU : ALUOP_LT) : ALUOP_SUB;
		d_branchcond_o = (funct3[0] ^ funct3[2]) ? BCOND_NZERO : BCOND_ZERO;
		invalid        = funct3[2:1] == 2'b01;
	end
	OPC_JAL: begin
		// Link value is PC + 4 from the ALU
		d_rs1_o        = X0;
		d_rs2_o        = X0;
		d_alusrc_a_o   = ALUSRCA_PC;
		d_alusrc_b_o   = ALUSRCB_IMM;
		d_imm_o        = PC_STEP;
		d_branchcond_o = BCOND_ALWAYS;
		// Without 16-bit instructions a halfword-aligned target is unreachable
		invalid        = imm_j_i[1];
	end
	OPC_JALR: begin
		d_rs2_o             = X0;
		d_alusrc_a_o        = ALUSRCA_PC;
		d_alusrc_b_o        = ALUSRCB_IMM;
		d_imm_o             = PC_STEP;
		d_branchcond_o      = BCOND_ALWAYS;
		d_addr_is_regoffs_o = 1'b1;
		invalid             = funct3 != 3'd0;
	end
	OPC_LUI: begin
		d_rs1_o      = X0;
		d_rs2_o      = X0;
		d_aluop_o    = ALUOP_RS2;
		d_alusrc_b_o = ALUSRCB_IMM;
		d_imm_o      = imm_u_i;
	end
	OPC_AUIPC: begin
		d_rs1_o      = X0;
		d_rs2_o      = X0;
		d_alusrc_a_o = ALUSRCA_PC;
		d_alusrc_b_o = ALUSRCB_IMM;
		d_imm_o      = imm_u_i;
	end
	OPC_OP_IMM: begin
		d_rs2_o      = X0;
		d_alusrc_b_o = ALUSRCB_IMM;
		d_aluop_o    = alu_from_funct3(funct3, funct3 == 3'b101 && funct7 == FUNCT7_ALT);
		// Shift amounts leave funct7 as the only shift-type field
		if (funct3 == 3'b001)
			invalid = funct7 != 7'd0;
		else if (funct3 == 3'b101)
			invalid = funct7 != 7'd0 && funct7 != FUNCT7_ALT;
	end
	OPC_OP: begin
		if (funct7 == FUNCT7_MULDIV) begin
			d_aluop_o = ALUOP_MULDIV;
			d_mulop_o = funct3;
		end else begin
			d_aluop_o = alu_from_funct3(funct3, funct7 == FUNCT7_ALT);
			invalid   = funct7 == FUNCT7_ALT ? (funct3 != 3'b000 && funct3 != 3'b101) :
				funct7 != 7'd0;
		end
	end
	OPC_LOAD: begin
		d_rs2_o             = X0;
		d_addr_is_regoffs_o = 1'b1;
		case (funct3)
		3'b000:  d_memop_o = MEMOP_LB;
		3'b001:  d_memop_o = MEMOP_LH;
		3'b010:  d_memop_o = MEMOP_LW;
		3'b100:  d_memop_o = MEMOP_LBU;
		3'b101:  d_memop_o = MEMOP_LHU;
		default: invalid = 1'b1;
		endcase
	end
	OPC_STORE: begin
		// Store data passes through the ALU from rs2
		d_rd_o              = X0;
		d_aluop_o           = ALUOP_RS2;
		d_addr_is_regoffs_o = 1'b1;
		case (funct3)
		3'b000:  d_memop_o = MEMOP_SB;
		3'b001:  d_memop_o = MEMOP_SH;
		3'b010:  d_memop_o = MEMOP_SW;
		default: invalid = 1'b1;
		endcase
	end
	OPC_FENCE: begin
		// No-op, rs1 and rd are already zero in the encoding
		d_rs2_o = X0;
		invalid = funct3 != 3'b000;
	end
	OPC_SYSTEM: begin
		d_rs1_o    = X0;
		d_rs2_o    = X0;
		d_rd_o     = X0;
		d_except_o = instr_i.r.rs2[0] ? EXCEPT_EBREAK : EXCEPT_ECALL_M;
		invalid    = !sys_base;
	end
	default: begin
		invalid = 1'b1;
	end
	endcase

	// ----------------------------------------
	// Squash anything that must not reach execute
	if (invalid || starved_i || bus_fault_i) begin
		d_rs1_o        = X0;
		d_rs2_o        = X0;
		d_rd_o         = X0;
		d_memop_o      = MEMOP_NONE;
		d_branchcond_o = BCOND_NEVER;
		d_aluop_o      = ALUOP_ADD;
		if (bus_fault_i)
			d_except_o = EXCEPT_INSTR_FAULT;
		else if (!starved_i)
			d_except_o = EXCEPT_INSTR_ILLEGAL;
		else
			d_except_o = EXCEPT_NONE;
	end
end

endmodule

// ==== src/rv_decode_top.sv ====
`timescale 1ns/10ps

module rv_decode_top
	import rv_decode_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,

	// Fetch side
	input  instr_t               fd_cir_i,
	input  logic [1:0]           fd_cir_vld_i,
	input  logic [1:0]           fd_cir_err_i,
	output logic [1:0]           df_cir_use_o,
	input  logic                 f_jump_now_i,
	input  logic [W_ADDR-1:0]    f_jump_target_i,

	// Execute side
	input  logic                 x_stall_i,
	output logic [W_ADDR-1:0]    d_pc_o,
	output logic                 d_starved_o,
	output logic [W_REGADDR-1:0] d_rs1_o,
	output logic [W_REGADDR-1:0] d_rs2_o,
	output logic [W_REGADDR-1:0] d_rd_o,
	output logic [W_DATA-1:0]    d_imm_o,
	output logic [W_ALUSRC-1:0]  d_alusrc_a_o,
	output logic [W_ALUSRC-1:0]  d_alusrc_b_o,
	output logic [W_ALUOP-1:0]   d_aluop_o,
	output logic [W_MEMOP-1:0]   d_memop_o,
	output logic [W_MULOP-1:0]   d_mulop_o,
	output logic [W_BCOND-1:0]   d_branchcond_o,
	output logic [W_DATA-1:0]    d_addr_offs_o,
	output logic                 d_addr_is_regoffs_o,
	output logic [W_EXCEPT-1:0]  d_except_o
);

logic              d_bus_fault;
logic [W_DATA-1:0] imm_i;
logic [W_DATA-1:0] imm_u;
logic [W_DATA-1:0] imm_j;

rv_pc_ctrl u_pc_ctrl (
	.clk             (clk),
	.rst_n           (rst_n),
	.fd_cir_vld_i    (fd_cir_vld_i),
	.fd_cir_err_i    (fd_cir_err_i),
	.x_stall_i       (x_stall_i),
	.f_jump_now_i    (f_jump_now_i),
	.f_jump_target_i (f_jump_target_i),
	.d_pc_o          (d_pc_o),
	.df_cir_use_o    (df_cir_use_o),
	.d_starved_o     (d_starved_o),
	.d_bus_fault_o   (d_bus_fault)
);

rv_imm_gen u_imm_gen (
	.instr_i     (fd_cir_i),
	.imm_i_o     (imm_i),
	.imm_u_o     (imm_u),
	.imm_j_o     (imm_j),
	.addr_offs_o (d_addr_offs_o)
);

rv_ctrl_decode u_ctrl_decode (
	.instr_i             (fd_cir_i),
	.imm_i_i             (imm_i),
	.imm_u_i             (imm_u),
	.imm_j_i             (imm_j),
	.starved_i           (d_starved_o),
	.bus_fault_i         (d_bus_fault),
	.d_rs1_o             (d_rs1_o),
	.d_rs2_o             (d_rs2_o),
	.d_rd_o              (d_rd_o),
	.d_imm_o             (d_imm_o),
	.d_alusrc_a_o        (d_alusrc_a_o),
	.d_alusrc_b_o        (d_alusrc_b_o),
	.d_aluop_o           (d_aluop_o),
	.d_memop_o           (d_memop_o),
	.d_mulop_o           (d_mulop_o),
	.d_branchcond_o      (d_branchcond_o),
	.d_addr_is_regoffs_o (d_addr_is_regoffs_o),
	.d_except_o          (d_except_o)
);

endmodule

// ==== test/tb_rv_decode.sv ====
`timescale 1ns/10ps

module tb_rv_decode
	import rv_decode_pkg::*;
();

logic                 clk;
logic                 rst_n;
instr_t               fd_cir_i;
logic [1:0]           fd_cir_vld_i;
logic [1:0]           fd_cir_err_i;
logic                 x_stall_i;
logic                 f_jump_now_i;
logic [W_ADDR-1:0]    f_jump_target_i;

logic [1:0]           df_cir_use_o;
logic [W_ADDR-1:0]    d_pc_o;
logic                 d_starved_o;
logic [W_REGADDR-1:0] d_rs1_o;
logic [W_REGADDR-1:0] d_rs2_o;
logic [W_REGADDR-1:0] d_rd_o;
logic [W_DATA-1:0]    d_imm_o;
logic [W_ALUSRC-1:0]  d_alusrc_a_o;
logic [W_ALUSRC-1:0]  d_alusrc_b_o;
logic [W_ALUOP-1:0]   d_aluop_o;
logic [W_MEMOP-1:0]   d_memop_o;
logic [W_MULOP-1:0]   d_mulop_o;
logic [W_BCOND-1:0]   d_branchcond_o;
logic [W_DATA-1:0]    d_addr_offs_o;
logic                 d_addr_is_regoffs_o;
logic [W_EXCEPT-1:0]  d_except_o;

// Fields of the current case line
logic [31:0]          fld [0:12];
logic [W_ADDR-1:0]    exp_pc;
string                where;

always #10 clk = ~clk;

rv_decode_top u_dut (
	.clk                 (clk),
	.rst_n               (rst_n),
	.fd_cir_i            (fd_cir_i),
	.fd_cir_vld_i        (fd_cir_vld_i),
	.fd_cir_err_i        (fd_cir_err_i),
	.df_cir_use_o        (df_cir_use_o),
	.f_jump_now_i        (f_jump_now_i),
	.f_jump_target_i     (f_jump_target_i),
	.x_stall_i           (x_stall_i),
	.d_pc_o              (d_pc_o),
	.d_starved_o         (d_starved_o),
	.d_rs1_o             (d_rs1_o),
	.d_rs2_o             (d_rs2_o),
	.d_rd_o              (d_rd_o),
	.d_imm_o             (d_imm_o),
	.d_alusrc_a_o        (d_alusrc_a_o),
	.d_alusrc_b_o        (d_alusrc_b_o),
	.d_aluop_o           (d_aluop_o),
	.d_memop_o           (d_memop_o),
	.d_mulop_o           (d_mulop_o),
	.d_branchcond_o      (d_branchcond_o),
	.d_addr_offs_o       (d_addr_offs_o),
	.d_addr_is_regoffs_o (d_addr_is_regoffs_o),
	.d_except_o          (d_except_o)
);

// ----------------------------------------
// Reporting and compare

task automatic abort_test(input string why);
	$display("%s", why);
	$display("Test FAILED");
	$fatal(1, "stopped at first error");
endtask

task automatic check_reg(input string name, input logic [W_REGADDR-1:0] act,
	input logic [W_REGADDR-1:0] exp);
	if (act !== exp)
		abort_test($sformatf("Fail %s (%s): got %h, expected %h", name, where, act, exp));
endtask

task automatic check_word(input string name, input logic [W_DATA-1:0] act,
	input logic [W_DATA-1:0] exp);
	if (act !== exp)
		abort_test($sformatf("Fail %s (%s): got %h, expected %h", name, where, act, exp));
endtask

// Narrower codes are zero-extended by the caller
task automatic check_code(input string name, input logic [W_ALUOP-1:0] act,
	input logic [W_ALUOP-1:0] exp);
	if (act !== exp)
		abort_test($sformatf("Fail %s (%s): got %h, expected %h", name, where, act, exp));
endtask

task automatic check_pc(input string name, input logic [W_ADDR-1:0] act,
	input logic [W_ADDR-1:0] exp);
	if (act !== exp)
		abort_test($sformatf("Fail %s (%s): got %h, expected %h", name, where, act, exp));
endtask

// ----------------------------------------
// Stimulus

task automatic wait_accept(input int max_cycles);
	int waited;
	waited = 0;
	@(negedge clk);
	while (df_cir_use_o != 2'd2) begin
		if (waited >= max_cycles) begin
			abort_test("Timeout while waiting for decode to accept an instruction");
		end else begin
			waited++;
			@(negedge clk);
		end
	end
endtask

// Operand A source, operand B source and register-relative addressing
// Links are PC + 4, so jumps take the PC and the immediate
function automatic logic [2:0] operand_ctrl_for(input logic [6:0] opcode);
	case (opcode)
	OPC_JAL, OPC_AUIPC:  return {ALUSRCA_PC, ALUSRCB_IMM, 1'b0};
	OPC_JALR:            return {ALUSRCA_PC, ALUSRCB_IMM, 1'b1};
	OPC_LUI, OPC_OP_IMM: return {ALUSRCA_RS1, ALUSRCB_IMM, 1'b0};
	OPC_LOAD, OPC_STORE: return {ALUSRCA_RS1, ALUSRCB_RS2, 1'b1};
	default:             return {ALUSRCA_RS1, ALUSRCB_RS2, 1'b0};
	endcase
endfunction

// Stall stays high, so the PC must not move while cases run
task automatic apply_case();
	logic [2:0] ops;
	ops = operand_ctrl_for(fld[0][6:0]);
	@(posedge clk);
	fd_cir_i     <= fld[0];
	fd_cir_vld_i <= fld[1][1:0];
	fd_cir_err_i <= fld[2][1:0];
	@(negedge clk);
	check_reg("d_rs1_o", d_rs1_o, fld[3][W_REGADDR-1:0]);
	check_reg("d_rs2_o", d_rs2_o, fld[4][W_REGADDR-1:0]);
	check_reg("d_rd_o", d_rd_o, fld[5][W_REGADDR-1:0]);
	check_word("d_imm_o", d_imm_o, fld[6]);
	check_code("d_aluop_o", d_aluop_o, fld[7][3:0]);
	check_code("d_memop_o", d_memop_o, fld[8][3:0]);
	check_code("d_mulop_o", {1'b0, d_mulop_o}, fld[9][3:0]);
	check_code("d_branchcond_o", {2'b00, d_branchcond_o}, fld[10][3:0]);
	check_code("d_except_o", {1'b0, d_except_o}, fld[11][3:0]);
	check_word("d_addr_offs_o", d_addr_offs_o, fld[12]);
	check_code("d_alusrc_a_o", {3'b000, d_alusrc_a_o}, {3'b000, ops[2]});
	check_code("d_alusrc_b_o", {3'b000, d_alusrc_b_o}, {3'b000, ops[1]});
	check_code("d_addr_is_regoffs_o", {3'b000, d_addr_is_regoffs_o}, {3'b000, ops[0]});
	check_code("d_starved_o", {3'b000, d_starved_o}, (fld[1] < 32'd2) ? 4'd1 : 4'd0);
	check_code("df_cir_use_o", {2'b00, df_cir_use_o}, 4'd0);
	check_pc("d_pc_o", d_pc_o, RESET_VECTOR);
endtask

// One clock with vld at 2, then predict the PC for the following edge
task automatic drive_step(input logic stall, input logic jump,
	input logic [W_ADDR-1:0] target);
	@(posedge clk);
	x_stall_i       <= stall;
	f_jump_now_i    <= jump;
	f_jump_target_i <= target;
	@(negedge clk);
	check_pc("d_pc_o", d_pc_o, exp_pc);
	check_code("df_cir_use_o", {2'b00, df_cir_use_o}, stall ? 4'd0 : 4'd2);
	if (jump)
		exp_pc = target;
	else if (!stall)
		exp_pc = exp_pc + PC_STEP;
endtask

// ----------------------------------------
// Main sequence

initial begin
	int    fd;
	int    n;
	int    got;
	string line;

	clk             = 1'b0;
	rst_n           = 1'b0;
	fd_cir_i        = '0;
	fd_cir_vld_i    = 2'd0;
	fd_cir_err_i    = 2'b00;
	x_stall_i       = 1'b1;
	f_jump_now_i    = 1'b0;
	f_jump_target_i = '0;
	exp_pc          = RESET_VECTOR;
	where           = "reset";

	repeat (4) @(posedge clk);
	rst_n <= 1'b1;
	@(negedge clk);
	check_pc("d_pc_o", d_pc_o, RESET_VECTOR);
	check_code("d_starved_o", {3'b000, d_starved_o}, 4'd1);
	check_code("df_cir_use_o", {2'b00, df_cir_use_o}, 4'd0);
	check_code("d_memop_o", d_memop_o, MEMOP_NONE);
	check_code("d_branchcond_o", {2'b00, d_branchcond_o}, {2'b00, BCOND_NEVER});
	check_code("d_except_o", {1'b0, d_except_o}, {1'b0, EXCEPT_NONE});

	fd = $fopen("test/decode_cases.txt", "r");
	if (fd == 0)
		abort_test("Could not open the case file test/decode_cases.txt");
	n = 0;
	while ($fgets(line, fd) != 0) begin
		got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
			fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
			fld[7], fld[8], fld[9], fld[10], fld[11], fld[12]);
		// Comment and blank lines scan as nothing
		if (got == 13) begin
			n++;
			where = $sformatf("case %0d", n);
			apply_case();
		end else if (got > 0) begin
			abort_test($sformatf("Malformed line in the case file after case %0d", n));
		end
	end
	$fclose(fd);
	if (n == 0)
		abort_test("The case file holds no cases");

	where = "PC sequence";
	@(posedge clk);
	fd_cir_i     <= 32'h0000_0013;
	fd_cir_vld_i <= 2'd2;
	fd_cir_err_i <= 2'b00;
	drive_step(1'b1, 1'b0, '0);
	drive_step(1'b1, 1'b0, '0);

	// Release the stall and wait for the first accept
	@(posedge clk);
	x_stall_i <= 1'b0;
	wait_accept(8);
	check_pc("d_pc_o", d_pc_o, exp_pc);
	exp_pc = exp_pc + PC_STEP;
	repeat (3) drive_step(1'b0, 1'b0, '0);

	// Hold under stall, then a jump that lands while still stalled
	drive_step(1'b1, 1'b0, '0);
	drive_step(1'b1, 1'b0, '0);
	drive_step(1'b1, 1'b1, 32'h0000_1000);
	drive_step(1'b1, 1'b0, '0);
	drive_step(1'b0, 1'b0, '0);
	drive_step(1'b0, 1'b1, 32'h0000_2000);
	drive_step(1'b0, 1'b0, '0);
	drive_step(1'b0, 1'b0, '0);

	$display("Test OK");
	$finish;
end

endmodule

// ==== test/decode_cases.txt ====
# Columns in hex: instr vld err, then expected rs1 rs2 rd imm aluop memop
# mulop branchcond except addr_offs
00208463 2 0 01 02 00 00000002 1 f 0 2 0 00000008
fe41cee3 2 0 03 04 00 ffffffe4 2 f 0 3 0 fffffffc
0062f863 2 0 05 06 00 00000006 4 f 0 2 0 00000010
008000ef 2 0 00 00 01 00000004 0 f 0 1 0 00000008
002000ef 2 0 00 00 00 00000004 0 f 0 0 2 00000002
00c280e7 2 0 05 00 01 00000004 0 f 0 1 0 0000000c
ff812383 2 0 02 00 07 fffffff8 0 0 0 0 0 fffffff8
0034c403 2 0 09 00 08 00000003 0 4 0 0 0 00000003
00612a23 2 0 02 06 00 00000006 3 5 0 0 0 00000014
fe740fa3 2 0 08 07 00 ffffffe7 3 7 0 0 0 ffffffff
123452b7 2 0 00 00 05 12345000 3 f 0 0 0 00000000
fffff317 2 0 00 00 06 fffff000 0 f 0 0 0 00000000
ffb10093 2 0 02 00 01 fffffffb 0 f 0 0 0 00000000
40725193 2 0 04 00 03 00000407 a f 0 0 0 00000000
403100b3 2 0 02 03 01 00000403 1 f 0 0 0 00000000
0062f233 2 0 05 06 04 00000006 8 f 0 0 0 00000000
009413b3 2 0 08 09 07 00000009 b f 0 0 0 00000000
023100b3 2 0 02 03 01 00000023 c f 0 0 0 00000000
023110b3 2 0 02 03 01 00000023 c f 1 0 0 00000000
023120b3 2 0 02 03 01 00000023 c f 2 0 0 00000000
023130b3 2 0 02 03 01 00000023 c f 3 0 0 00000000
023140b3 2 0 02 03 01 00000023 c f 4 0 0 00000000
023150b3 2 0 02 03 01 00000023 c f 5 0 0 00000000
023160b3 2 0 02 03 01 00000023 c f 6 0 0 00000000
023170b3 2 0 02 03 01 00000023 c f 7 0 0 00000000
00000073 2 0 00 00 00 00000000 0 f 0 0 3 00000000
00100073 2 0 00 00 00 00000001 0 f 0 0 4 00000000
0ff0000f 2 0 00 00 00 000000ff 0 f 0 0 0 00000000
0021a0af 2 0 00 00 00 00000002 0 f 0 0 2 00000000
300110f3 2 0 00 00 00 00000300 0 f 0 0 2 00000000
403170b3 2 0 00 00 00 00000403 0 f 0 0 2 00000000
ffb10093 2 1 00 00 00 fffffffb 0 f 0 0 1 00000000
0021a0af 2 2 00 00 00 00000002 0 f 0 0 1 00000000
ff812383 1 1 00 00 00 fffffff8 0 f 0 0 1 fffffff8
00208463 1 2 00 00 00 00000002 0 f 0 0 0 00000008
00000000 0 0 00 00 00 00000000 0 f 0 0 0 00000000
008000ef 1 0 00 00 00 00000004 0 f 0 0 0 00000008

// ==== sim.f ====
src/rv_decode_pkg.sv
src/rv_pc_ctrl.sv
src/rv_imm_gen.sv
src/rv_ctrl_decode.sv
src/rv_decode_top.sv
test/tb_rv_decode.sv

// ==== Makefile ====
TOP = tb_rv_decode

.PHONY: sim clean

sim:
	verilator --binary --timing -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
